/* cache_pkg.sv */
package cache_pkg;

    // Cache and memory sizes
    localparam int NUM_LINES   = 8;
    localparam int LINE_BYTES  = 16;
    localparam int WORD_BYTES  = 4;
    localparam int SB_DEPTH    = 4;
    localparam int MEM_LATENCY = 4;

    localparam int INDEX_BITS  = $clog2(NUM_LINES);
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

    localparam int ADDR_BITS       = 16;
    localparam int LINE_ADDR_BITS  = ADDR_BITS - OFFSET_BITS;
    localparam int TAG_BITS        = LINE_ADDR_BITS - INDEX_BITS;
    localparam int LINE_WORDS      = LINE_BYTES / WORD_BYTES;
    localparam int WORD_SEL_BITS   = $clog2(LINE_WORDS);
    localparam int MEM_LINES       = 1 << LINE_ADDR_BITS;
    localparam int SB_PTR_BITS     = $clog2(SB_DEPTH);
    localparam int SB_COUNT_BITS   = $clog2(SB_DEPTH + 1);
    localparam int LATENCY_BITS    = $clog2(MEM_LATENCY + 1);

    typedef logic [ADDR_BITS-1:0]        addr_t;
    typedef logic [LINE_ADDR_BITS-1:0]   line_addr_t;
    typedef logic [TAG_BITS-1:0]         tag_t;
    typedef logic [INDEX_BITS-1:0]       index_t;

    // Little-endian bytes within a word, words within a line
    typedef logic [WORD_BYTES-1:0][7:0]  word_t;
    typedef word_t [LINE_WORDS-1:0]      line_t;

    typedef logic [WORD_BYTES-1:0]       byte_mask_t;
    typedef byte_mask_t [LINE_WORDS-1:0] line_mask_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } access_mode_e;

    typedef enum logic [1:0] {
        INVALID,
        VALID,
        REQUESTED
    } line_state_e;

    // Bytes of a word touched by an aligned access
    function automatic byte_mask_t access_mask(access_mode_e mode, logic [1:0] offset);
        case (mode)
            BYTE:    access_mask = byte_mask_t'(1) << offset;
            HALF:    access_mask = offset[1] ? 4'b1100 : 4'b0011;
            default: access_mask = '1;
        endcase
    endfunction

endpackage

/* cache_ifs.sv */
`timescale 1ns/1ps

interface cache_request_if import cache_pkg::*; ();
    logic         read;
    logic         write;
    access_mode_e mode;
    addr_t        addr;
    word_t        data;

    modport source   (output read, write, mode, addr, data);
    modport consumer (input read, write, mode, addr, data);
endinterface

interface mem_bus_request_if import cache_pkg::*; ();
    logic       read;
    logic       write;
    line_addr_t addr;
    line_t      data;

    modport source   (output read, write, addr, data);
    modport consumer (input read, write, addr, data);
endinterface

interface mem_bus_response_if import cache_pkg::*; ();
    logic       valid;
    logic       write_done;
    line_addr_t addr;
    line_t      data;

    modport source   (output valid, write_done, addr, data);
    modport consumer (input valid, write_done, addr, data);
endinterface

interface store_drain_if import cache_pkg::*; ();
    logic       pop;
    addr_t      addr;
    word_t      data;
    byte_mask_t mask;
    logic       empty;

    modport source   (input pop, output addr, data, mask, empty);
    modport consumer (output pop, input addr, data, mask, empty);
endinterface

/* store_buffer.sv */
`timescale 1ns/1ps

module store_buffer import cache_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 push,
    input  access_mode_e         mode,
    input  addr_t                addr,
    input  word_t                wdata,
    store_drain_if.source        drain,
    output byte_mask_t           hit_bytes,
    output word_t                fwd_data,
    output logic [NUM_LINES-1:0] pending_lines,
    output logic                 full
);

    addr_t      entry_addr [SB_DEPTH];
    word_t      entry_data [SB_DEPTH];
    byte_mask_t entry_mask [SB_DEPTH];

    logic [SB_PTR_BITS-1:0]   head;
    logic [SB_PTR_BITS-1:0]   tail;
    logic [SB_COUNT_BITS-1:0] count;

    addr_t word_addr;
    word_t lane_data;

    assign word_addr = {addr[ADDR_BITS-1:2], 2'b00};

    // Narrow data copied to every lane, the mask keeps the right one
    always_comb begin
        case (mode)
            BYTE:    lane_data = {WORD_BYTES{wdata[0]}};
            HALF:    lane_data = {2{wdata[1:0]}};
            default: lane_data = wdata;
        endcase
    end

    // Walk oldest to newest so the newest store wins each byte
    always_comb begin : forward
        logic [SB_PTR_BITS-1:0] slot;
        hit_bytes     = '0;
        fwd_data      = '0;
        pending_lines = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            slot = head + SB_PTR_BITS'(i);
            if (SB_COUNT_BITS'(i) < count) begin
                pending_lines[entry_addr[slot][OFFSET_BITS +: INDEX_BITS]] = 1'b1;
                if (entry_addr[slot] == word_addr) begin
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (entry_mask[slot][b]) begin
                            hit_bytes[b] = 1'b1;
                            fwd_data[b]  = entry_data[slot][b];
                        end
                    end
                end
            end
        end
    end

    assign drain.addr  = entry_addr[head];
    assign drain.data  = entry_data[head];
    assign drain.mask  = entry_mask[head];
    assign drain.empty = (count == '0);
    assign full        = (count == SB_COUNT_BITS'(SB_DEPTH));

    always_ff @(posedge clock) begin
        if (push) begin
            entry_addr[tail] <= word_addr;
            entry_data[tail] <= lane_data;
            entry_mask[tail] <= access_mask(mode, addr[1:0]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (drain.pop) begin
                head <= head + 1'b1;
            end
            case ({push, drain.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The cache only accepts a store into a full buffer when it drains one
    assert property (@(posedge clock) disable iff (reset) push && full |-> drain.pop)
        else $error("store buffer push while full without a pop");

endmodule

/* data_cache.sv */
`timescale 1ns/1ps

module data_cache import cache_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    cache_request_if.consumer    request,
    input  logic                 mem_bus_available,
    mem_bus_request_if.source    mem_request,
    mem_bus_response_if.consumer mem_response,
    output logic                 hit,
    output word_t                rdata
);

    line_state_e state [NUM_LINES];
    tag_t        tags  [NUM_LINES];
    line_mask_t  dirty [NUM_LINES];
    line_t       lines [NUM_LINES];

    store_drain_if drain ();

    byte_mask_t           sb_hit_bytes;
    word_t                sb_fwd_data;
    logic [NUM_LINES-1:0] sb_pending;
    logic                 sb_full;
    logic                 sb_push;
    logic                 sb_pop;

    store_buffer u_store_buffer (
        .clock         (clock),
        .reset         (reset),
        .push          (sb_push),
        .mode          (request.mode),
        .addr          (request.addr),
        .wdata         (request.data),
        .drain         (drain),
        .hit_bytes     (sb_hit_bytes),
        .fwd_data      (sb_fwd_data),
        .pending_lines (sb_pending),
        .full          (sb_full)
    );

    index_t                   req_index;
    tag_t                     req_tag;
    logic [WORD_SEL_BITS-1:0] req_word;
    line_state_e              cur_state;
    logic                     tag_match;
    logic                     line_dirty;
    byte_mask_t               bank_bytes;
    byte_mask_t               need_bytes;
    word_t                    bank_word;
    word_t                    merged;
    word_t                    shifted;
    logic                     read_hit;
    logic                     write_hit;
    logic                     miss;
    logic                     blocked;

    assign req_index  = request.addr[OFFSET_BITS +: INDEX_BITS];
    assign req_tag    = request.addr[ADDR_BITS-1 -: TAG_BITS];
    assign req_word   = request.addr[2 +: WORD_SEL_BITS];
    assign cur_state  = state[req_index];
    assign tag_match  = cur_state != INVALID && tags[req_index] == req_tag;
    assign line_dirty = |dirty[req_index];
    assign bank_word  = lines[req_index][req_word];

    // A pending fetch only provides the bytes already stored into it
    assign bank_bytes = !tag_match          ? '0 :
                        cur_state == VALID  ? '1 : dirty[req_index][req_word];

    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            merged[b] = sb_hit_bytes[b] ? sb_fwd_data[b] : bank_word[b];
        end
    end

    assign need_bytes = access_mask(request.mode, request.addr[1:0]);
    assign read_hit   = (need_bytes & ~(bank_bytes | sb_hit_bytes)) == '0;
    assign sb_pop     = !drain.empty && !mem_response.valid;
    assign write_hit  = tag_match && (!sb_full || sb_pop);
    assign sb_push    = request.write && write_hit;
    assign drain.pop  = sb_pop;

    assign hit = (request.read && read_hit) || (request.write && write_hit);

    assign shifted = merged >> {request.addr[1:0], 3'b000};

    always_comb begin
        case (request.mode)
            BYTE:    rdata = {24'b0, shifted[0]};
            HALF:    rdata = {16'b0, shifted[1:0]};
            default: rdata = merged;
        endcase
    end

    // Wait while the line has queued stores or a fetch in flight
    assign miss    = (request.read && !read_hit) || (request.write && !tag_match);
    assign blocked = !mem_bus_available || sb_pending[req_index] || cur_state == REQUESTED;

    assign mem_request.read  = miss && !blocked && (cur_state == INVALID || !line_dirty);
    assign mem_request.write = miss && !blocked && cur_state == VALID && line_dirty;
    assign mem_request.addr  = mem_request.write ? {tags[req_index], req_index}
                                                 : {req_tag, req_index};
    assign mem_request.data  = lines[req_index];

    index_t                   fill_index;
    index_t                   drain_index;
    logic [WORD_SEL_BITS-1:0] drain_word;

    assign fill_index  = mem_response.addr[INDEX_BITS-1:0];
    assign drain_index = drain.addr[OFFSET_BITS +: INDEX_BITS];
    assign drain_word  = drain.addr[2 +: WORD_SEL_BITS];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state[i] <= INVALID;
                dirty[i] <= '0;
            end
        end else begin
            if (mem_request.read) begin
                state[req_index] <= REQUESTED;
            end
            if (mem_response.write_done) begin
                state[fill_index] <= INVALID;
                dirty[fill_index] <= '0;
            end
            // Bytes stored during the fetch stay dirty
            if (mem_response.valid) begin
                state[fill_index] <= VALID;
            end
            if (sb_pop) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (drain.mask[b]) begin
                        dirty[drain_index][drain_word][b] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_request.read) begin
            tags[req_index] <= req_tag;
        end
        if (mem_response.valid) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (!dirty[fill_index][w][b]) begin
                        lines[fill_index][w][b] <= mem_response.data[w][b];
                    end
                end
            end
        end
        if (sb_pop) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (drain.mask[b]) begin
                    lines[drain_index][drain_word][b] <= drain.data[b];
                end
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_response.valid |-> state[fill_index] == REQUESTED)
        else $error("memory fill for a line that was not requested");

    // A fetch must wait until the write-back of the line has completed
    assert property (@(posedge clock) disable iff (reset)
        mem_request.read |-> dirty[req_index] == '0)
        else $error("fetch requested before the dirty line was written back");

endmodule

/* main_memory.sv */
`timescale 1ns/1ps

module main_memory import cache_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    mem_bus_request_if.consumer request,
    mem_bus_response_if.source  response,
    output logic                available
);

    line_t mem [MEM_LINES];

    logic                    busy;
    logic                    is_write;
    logic                    done;
    logic [LATENCY_BITS-1:0] countdown;
    line_addr_t              pend_addr;
    line_t                   pend_data;

    // Known pattern so reads of untouched lines can be predicted
    initial begin
        for (int a = 0; a < MEM_LINES; a++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                mem[a][b / WORD_BYTES][b % WORD_BYTES] = 8'(a * LINE_BYTES + b) ^ 8'h5A;
            end
        end
    end

    assign done      = busy && countdown == '0;
    assign available = !busy;

    assign response.valid      = done && !is_write;
    assign response.write_done = done && is_write;
    assign response.addr       = pend_addr;
    assign response.data       = mem[pend_addr];

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            countdown <= '0;
        end else if (request.read || request.write) begin
            busy      <= 1'b1;
            countdown <= LATENCY_BITS'(MEM_LATENCY - 1);
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            countdown <= countdown - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (request.read || request.write) begin
            pend_addr <= request.addr;
            pend_data <= request.data;
            is_write  <= request.write;
        end
        if (done && is_write) begin
            mem[pend_addr] <= pend_data;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        busy |-> !(request.read || request.write))
        else $error("memory request while busy");

endmodule

/* cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem import cache_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         req_read,
    input  logic         req_write,
    input  access_mode_e req_mode,
    input  addr_t        req_addr,
    input  word_t        req_wdata,
    output logic         resp_hit,
    output word_t        resp_rdata
);

    cache_request_if    request_bus ();
    mem_bus_request_if  mem_request_bus ();
    mem_bus_response_if mem_response_bus ();

    logic mem_bus_available;

    assign request_bus.read  = req_read;
    assign request_bus.write = req_write;
    assign request_bus.mode  = req_mode;
    assign request_bus.addr  = req_addr;
    assign request_bus.data  = req_wdata;

    data_cache u_data_cache (
        .clock             (clock),
        .reset             (reset),
        .request           (request_bus),
        .mem_bus_available (mem_bus_available),
        .mem_request       (mem_request_bus),
        .mem_response      (mem_response_bus),
        .hit               (resp_hit),
        .rdata             (resp_rdata)
    );

    main_memory u_main_memory (
        .clock     (clock),
        .reset     (reset),
        .request   (mem_request_bus),
        .response  (mem_response_bus),
        .available (mem_bus_available)
    );

endmodule

/* cache_checker.sv */
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         req_read,
    input  logic         req_write,
    input  access_mode_e req_mode,
    input  addr_t        req_addr,
    input  word_t        req_wdata,
    input  logic         resp_hit,
    input  word_t        resp_rdata,
    input  int           entry_index,
    input  word_t        expected,
    input  logic         expect_hit,
    output int           pass_count,
    output int           fail_count
);

    // Set when the sampled request began in the cycle that just ended
    logic fresh;

    // Values sampled at the edge where the request retires
    always @(posedge clock) begin
        if (reset) begin
            pass_count <= 0;
            fail_count <= 0;
            fresh      <= 1'b1;
        end else begin
            fresh <= resp_hit || !(req_read || req_write);
            if (resp_hit && req_write) begin
                $display("entry %0d: write %s addr 0x%h data 0x%h accepted",
                         entry_index, req_mode.name(), req_addr, req_wdata);
                pass_count <= pass_count + 1;
            end else if (resp_hit && req_read) begin
                if (resp_rdata !== expected) begin
                    $display("MISMATCH resp_rdata entry %0d %s addr 0x%h: expected 0x%h actual 0x%h",
                             entry_index, req_mode.name(), req_addr, expected, resp_rdata);
                    fail_count <= fail_count + 1;
                end else if (expect_hit && !fresh) begin
                    $display("entry %0d: read %s addr 0x%h missed although the line is cached",
                             entry_index, req_mode.name(), req_addr);
                    fail_count <= fail_count + 1;
                end else begin
                    $display("entry %0d: read %s addr 0x%h data 0x%h ok",
                             entry_index, req_mode.name(), req_addr, resp_rdata);
                    pass_count <= pass_count + 1;
                end
            end
        end
    end

endmodule

/* tb_cache.sv */
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

    localparam int CLOCK_PERIOD    = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int HIT_TIMEOUT     = 40;
    localparam int CYCLES_PER_TEST = 2 * (MEM_LATENCY + 3) + 8;

    typedef struct packed {
        logic         is_write;
        access_mode_e mode;
        addr_t        addr;
        word_t        wdata;
        word_t        expected;
        logic         burst;
        logic         cached;
    } entry_t;

    logic         clock;
    logic         reset;
    logic         req_read;
    logic         req_write;
    access_mode_e req_mode;
    addr_t        req_addr;
    word_t        req_wdata;
    logic         resp_hit;
    word_t        resp_rdata;

    int    entry_index;
    word_t expected_data;
    logic  expect_hit;
    int    pass_count;
    int    fail_count;
    int    timeout_count;

    entry_t      stimulus [$];
    logic [7:0]  shadow [addr_t];
    logic [15:0] lfsr_state;

    cache_subsystem cache_subsystem_inst (
        .clock      (clock),
        .reset      (reset),
        .req_read   (req_read),
        .req_write  (req_write),
        .req_mode   (req_mode),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_hit   (resp_hit),
        .resp_rdata (resp_rdata)
    );

    cache_checker checker_inst (
        .clock       (clock),
        .reset       (reset),
        .req_read    (req_read),
        .req_write   (req_write),
        .req_mode    (req_mode),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .resp_hit    (resp_hit),
        .resp_rdata  (resp_rdata),
        .entry_index (entry_index),
        .expected    (expected_data),
        .expect_hit  (expect_hit),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Untouched bytes hold the low address byte XOR 0x5A
    function automatic logic [7:0] model_byte(addr_t a);
        return shadow.exists(a) ? shadow[a] : (a[7:0] ^ 8'h5A);
    endfunction

    function automatic word_t model_read(access_mode_e mode, addr_t addr);
        word_t value;
        addr_t base;
        value = '0;
        case (mode)
            BYTE: value[0] = model_byte(addr);
            HALF: begin
                base     = {addr[15:1], 1'b0};
                value[0] = model_byte(base);
                value[1] = model_byte(base + 16'd1);
            end
            default: begin
                base = {addr[15:2], 2'b00};
                for (int b = 0; b < WORD_BYTES; b++) begin
                    value[b] = model_byte(base + 16'(b));
                end
            end
        endcase
        return value;
    endfunction

    task automatic add_write(access_mode_e mode, addr_t addr, word_t wdata, logic burst);
        addr_t base;
        case (mode)
            BYTE: shadow[addr] = wdata[0];
            HALF: begin
                base               = {addr[15:1], 1'b0};
                shadow[base]       = wdata[0];
                shadow[base + 16'd1] = wdata[1];
            end
            default: begin
                base = {addr[15:2], 2'b00};
                for (int b = 0; b < WORD_BYTES; b++) begin
                    shadow[base + 16'(b)] = wdata[b];
                end
            end
        endcase
        stimulus.push_back(entry_t'{1'b1, mode, addr, wdata, 32'h0, burst, 1'b0});
    endtask

    task automatic add_read(access_mode_e mode, addr_t addr, logic burst);
        stimulus.push_back(entry_t'{1'b0, mode, addr, 32'h0, model_read(mode, addr), burst, 1'b0});
    endtask

    // Read that must hit in its first cycle
    task automatic add_cached_read(access_mode_e mode, addr_t addr, logic burst);
        stimulus.push_back(entry_t'{1'b0, mode, addr, 32'h0, model_read(mode, addr), burst, 1'b1});
    endtask

    task automatic build_stimulus();
        // Cold miss, then a hit on the same word
        add_read(WORD, 16'h0040, 1'b0);
        add_cached_read(WORD, 16'h0040, 1'b0);
        // Narrow stores into a cached line
        add_write(BYTE, 16'h0041, 32'h0000_00A5, 1'b0);
        add_cached_read(WORD, 16'h0040, 1'b1);
        add_write(HALF, 16'h0046, 32'h0000_BEEF, 1'b0);
        add_cached_read(HALF, 16'h0046, 1'b1);
        add_read(BYTE, 16'h0041, 1'b0);
        add_read(WORD, 16'h0044, 1'b0);
        // Write allocate on an invalid line
        add_write(BYTE, 16'h0106, 32'h0000_0077, 1'b0);
        add_write(HALF, 16'h0108, 32'h0000_1234, 1'b0);
        add_read(WORD, 16'h0104, 1'b0);
        add_read(WORD, 16'h0108, 1'b0);
        // Conflict on index 4 evicts the dirty line
        add_read(WORD, 16'h00C0, 1'b0);
        add_read(WORD, 16'h0040, 1'b0);
        add_read(WORD, 16'h0044, 1'b0);
        // Burst of stores, the first one evicts index 0
        add_write(WORD, 16'h0200, 32'h0102_0304, 1'b0);
        add_write(BYTE, 16'h0201, 32'h0000_00AA, 1'b1);
        add_write(HALF, 16'h0202, 32'h0000_CCDD, 1'b1);
        add_write(WORD, 16'h0204, 32'h5566_7788, 1'b1);
        add_write(BYTE, 16'h0200, 32'h0000_0099, 1'b1);
        add_read(WORD, 16'h0200, 1'b0);
        add_read(WORD, 16'h0204, 1'b0);
        add_read(WORD, 16'h0208, 1'b0);
        add_read(WORD, 16'h0104, 1'b0);
        add_read(HALF, 16'h0108, 1'b0);
    endtask

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Two LFSR bits give 0 to 3 idle cycles
    task automatic next_idle_gap(output int gap);
        lfsr_state = lfsr_next(lfsr_state);
        gap        = int'(lfsr_state[0]);
        lfsr_state = lfsr_next(lfsr_state);
        gap        = gap + 2 * int'(lfsr_state[0]);
    endtask

    initial begin : stimulus_driver
        int     gap;
        int     waited;
        logic   accepted;
        entry_t e;
        reset         = 1'b1;
        req_read      = 1'b0;
        req_write     = 1'b0;
        req_mode      = WORD;
        req_addr      = '0;
        req_wdata     = '0;
        entry_index   = 0;
        expected_data = '0;
        expect_hit    = 1'b0;
        timeout_count = 0;
        lfsr_state    = 16'd21181;
        build_stimulus();
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        foreach (stimulus[i]) begin
            e = stimulus[i];
            if (!e.burst) begin
                next_idle_gap(gap);
                req_read  <= 1'b0;
                req_write <= 1'b0;
                repeat (gap) @(posedge clock);
            end
            req_read      <= !e.is_write;
            req_write     <= e.is_write;
            req_mode      <= e.mode;
            req_addr      <= e.addr;
            req_wdata     <= e.wdata;
            entry_index   <= i;
            expected_data <= e.expected;
            expect_hit    <= e.cached;
            waited   = 0;
            accepted = 1'b0;
            while (!accepted && waited < HIT_TIMEOUT) begin
                @(posedge clock);
                waited   = waited + 1;
                accepted = resp_hit;
            end
            if (!accepted) begin
                $display("entry %0d: request at addr 0x%h never got a hit in %0d cycles",
                         i, e.addr, HIT_TIMEOUT);
                timeout_count = timeout_count + 1;
            end
        end
        req_read  <= 1'b0;
        req_write <= 1'b0;
        repeat (2) @(posedge clock);
        $display("summary: %0d passed, %0d failed, %0d timed out of %0d tests",
                 pass_count, fail_count, timeout_count, stimulus.size());
        if (fail_count == 0 && timeout_count == 0 && pass_count == stimulus.size()) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_cycles;
        #1;
        limit_cycles = stimulus.size() * CYCLES_PER_TEST + RESET_CYCLES;
        #(limit_cycles * CLOCK_PERIOD);
        $display("watchdog: run still busy after %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
cache_pkg.sv
cache_ifs.sv
store_buffer.sv
data_cache.sv
main_memory.sv
cache_subsystem.sv
cache_checker.sv
tb_cache.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f project.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_cache | tee /dev/stderr | grep -qx "TEST RESULT: PASS" \
    && exit 0 \
    || exit 1
